//--- verilog/rob_params.svh
//**********************************************************************
// Sizing macros for the reorder buffer: depth, tag width, data-bus port
// count and the data, address and register widths
//**********************************************************************

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Number of in-flight instructions the buffer can hold
`define ROB_DEPTH       8
// Index width for ROB_DEPTH entries
`define ROB_TAG_WIDTH   3
// Number of common data bus ports that write back results
`define ROB_CDB_DEPTH   2
`define ROB_DATA_WIDTH  32
`define ROB_ADDR_WIDTH  32
`define ROB_REG_WIDTH   5

`endif

//--- verilog/rob_types_pkg.sv
//**********************************************************************
// Instruction-side types: op encoding, tag and pointer types, the
// enqueue payload and the stored entry
//**********************************************************************

`include "rob_params.svh"

package rob_types_pkg;

    // Only integer and branch ops are tracked, loads and stores are not
    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_BR  = 2'b01
    } rob_op_e;

    typedef logic [`ROB_TAG_WIDTH-1:0]  tag_t;
    // Extra wrap bit lets full and empty be told apart when indices match
    typedef logic [`ROB_TAG_WIDTH:0]    ptr_t;
    typedef logic [`ROB_DATA_WIDTH-1:0] data_t;
    typedef logic [`ROB_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`ROB_REG_WIDTH-1:0]  reg_t;

    // Payload that arrives with the enqueue strobe
    typedef struct packed {
        rob_op_e op;
        addr_t   pc;
        reg_t    rdest;
    } enq_t;

    // One buffer slot
    // The rdy bit marks a completed result, redirect marks a flush on retire
    // and addr holds the branch target written back by the data bus
    typedef struct packed {
        logic    rdy;
        logic    redirect;
        rob_op_e op;
        addr_t   pc;
        addr_t   addr;
        data_t   data;
        reg_t    rdest;
    } entry_t;

endpackage

//--- verilog/rob_bus_pkg.sv
//**********************************************************************
// Bus-side records: data-bus broadcast, retire record to the register
// map and redirect record toward fetch
//**********************************************************************

package rob_bus_pkg;

    // One common data bus port, en qualifies all other fields
    typedef struct packed {
        logic                 en;
        logic                 redirect;
        rob_types_pkg::tag_t  tag;
        rob_types_pkg::data_t data;
        rob_types_pkg::addr_t addr;
    } cdb_t;

    // Result handed to the register map when an entry leaves the buffer
    typedef struct packed {
        rob_types_pkg::tag_t  tag;
        rob_types_pkg::reg_t  rdest;
        rob_types_pkg::data_t data;
    } retire_t;

    // Fetch restart request, the address is the branch target or the pc
    typedef struct packed {
        logic                 en;
        rob_types_pkg::addr_t addr;
    } redirect_t;

endpackage

//--- verilog/rob_alloc.sv
//**********************************************************************
// Tail allocator: tail pointer, full and empty flags, rename tag and
// the one-hot dispatch select for the following enqueue
//**********************************************************************

`timescale 1ns/1ps

`include "rob_params.svh"

module rob_alloc (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      i_rename_en,
    input  logic                      i_enq_en,
    input  logic                      i_retire_en,
    input  logic                      i_redirect,
    input  rob_types_pkg::ptr_t       i_head_next,
    output rob_types_pkg::tag_t       o_tail_addr,
    output logic [`ROB_DEPTH-1:0]     o_dispatch_en,
    output logic                      o_full,
    output logic                      o_empty
);

    rob_types_pkg::ptr_t   tail;
    rob_types_pkg::ptr_t   tail_next;
    logic                  rename_acc;
    logic [`ROB_DEPTH-1:0] dispatch_sel;

    // A rename while full is dropped
    assign rename_acc  = i_rename_en & ~o_full;
    assign o_tail_addr = tail[`ROB_TAG_WIDTH-1:0];

    // A flush pulls the tail back to slot 0 along with the head
    assign tail_next = i_redirect ? '0 :
                       rename_acc ? rob_types_pkg::ptr_t'(tail + 1'b1) : tail;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            tail <= '0;
        end else begin
            tail <= tail_next;
        end
    end

    // Full when the indices match but the wrap bits differ
    always_ff @(posedge clk) begin
        if (!n_rst || i_redirect) begin
            o_full  <= 1'b0;
            o_empty <= 1'b1;
        end else begin
            o_full  <= ({~tail_next[`ROB_TAG_WIDTH], tail_next[`ROB_TAG_WIDTH-1:0]} ==
                        i_head_next);
            o_empty <= (tail_next == i_head_next);
        end
    end

    // Remember which slot was reserved so the enqueue one cycle later lands there
    always_ff @(posedge clk) begin
        if (rename_acc) begin
            dispatch_sel <= {{(`ROB_DEPTH-1){1'b0}}, 1'b1} << o_tail_addr;
        end
    end

    assign o_dispatch_en = {(`ROB_DEPTH){i_enq_en}} & dispatch_sel;

    // The enqueue must follow an accepted rename by exactly one cycle
    assert property (@(posedge clk) disable iff (!n_rst)
        i_enq_en |-> $past(rename_acc));

    // A retirement frees a slot, so the buffer can't be full on the next cycle
    assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_en |=> !o_full);

endmodule

//--- verilog/rob_entry_array.sv
//**********************************************************************
// Entry storage: filled by enqueue, completed by data-bus broadcasts,
// ready bits cleared on a flush
//**********************************************************************

`timescale 1ns/1ps

`include "rob_params.svh"

module rob_entry_array (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic [`ROB_DEPTH-1:0]  i_dispatch_en,
    input  rob_types_pkg::enq_t    i_enq,
    input  rob_bus_pkg::cdb_t      i_cdb [0:`ROB_CDB_DEPTH-1],
    input  logic                   i_redirect,
    input  rob_types_pkg::tag_t    i_head_addr,
    output rob_types_pkg::entry_t  o_head_entry
);

    rob_types_pkg::entry_t entries   [0:`ROB_DEPTH-1];
    logic [`ROB_DEPTH-1:0] cdb_hit   [0:`ROB_CDB_DEPTH-1];
    logic [`ROB_DEPTH-1:0] rdy_next;
    logic [`ROB_DEPTH-1:0] redirect_next;
    rob_types_pkg::data_t  data_next [0:`ROB_DEPTH-1];
    rob_types_pkg::addr_t  addr_next [0:`ROB_DEPTH-1];

    // Decode each port's tag into a per-entry hit vector
    always_comb begin
        for (int p = 0; p < `ROB_CDB_DEPTH; p++) begin
            cdb_hit[p] = {(`ROB_DEPTH){i_cdb[p].en}} &
                         ({{(`ROB_DEPTH-1){1'b0}}, 1'b1} << i_cdb[p].tag);
        end
    end

    // Any hit makes the entry ready and ORs in the port's redirect flag
    // Data and address come from the last hitting port, so higher ports win
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rdy_next[i]      = entries[i].rdy;
            redirect_next[i] = entries[i].redirect;
            data_next[i]     = entries[i].data;
            addr_next[i]     = entries[i].addr;
            for (int p = 0; p < `ROB_CDB_DEPTH; p++) begin
                if (cdb_hit[p][i]) begin
                    rdy_next[i]      = 1'b1;
                    redirect_next[i] = redirect_next[i] | i_cdb[p].redirect;
                    data_next[i]     = i_cdb[p].data;
                    addr_next[i]     = i_cdb[p].addr;
                end
            end
        end
    end

    // Every slot comes out of reset not ready
    // A new instruction starts not ready and without a pending redirect
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (!n_rst) begin
                entries[i].rdy <= 1'b0;
            end else begin
                entries[i].rdy <= ~(i_redirect | i_dispatch_en[i]) & rdy_next[i];
            end
            entries[i].redirect <= ~i_dispatch_en[i] & redirect_next[i];
            entries[i].data     <= data_next[i];
            entries[i].addr     <= addr_next[i];
            if (i_dispatch_en[i]) begin
                entries[i].op    <= i_enq.op;
                entries[i].pc    <= i_enq.pc;
                entries[i].rdest <= i_enq.rdest;
            end
        end
    end

    assign o_head_entry = entries[i_head_addr];

    // A result can't come back for an instruction that is only now being filled
    for (genvar p = 0; p < `ROB_CDB_DEPTH; p++) begin : g_cdb_chk
        assert property (@(posedge clk) disable iff (!n_rst)
            i_cdb[p].en |-> !i_dispatch_en[i_cdb[p].tag]);
    end

endmodule

//--- verilog/rob_retire.sv
//**********************************************************************
// Retire unit: head pointer, retire enable, registered retire record
// and the one-cycle redirect with its target
//**********************************************************************

`timescale 1ns/1ps

`include "rob_params.svh"

module rob_retire (
    input  logic                   clk,
    input  logic                   n_rst,
    input  rob_types_pkg::entry_t  i_head_entry,
    input  logic                   i_empty,
    output rob_types_pkg::tag_t    o_head_addr,
    output rob_types_pkg::ptr_t    o_head_next,
    output logic                   o_retire_en,
    output logic                   o_redirect,
    output rob_types_pkg::addr_t   o_redirect_addr,
    output logic                   o_regmap_retire_en,
    output rob_bus_pkg::retire_t   o_regmap_retire
);

    rob_types_pkg::ptr_t head;

    assign o_head_addr = head[`ROB_TAG_WIDTH-1:0];

    // The head leaves once its result is in and the buffer holds something
    assign o_retire_en = i_head_entry.rdy & ~i_empty;

    // A flush overrides any retire in the same cycle and rewinds to slot 0
    assign o_head_next = o_redirect  ? '0 :
                         o_retire_en ? rob_types_pkg::ptr_t'(head + 1'b1) : head;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head <= '0;
        end else begin
            head <= o_head_next;
        end
    end

    // Retire pulse and redirect rise together one cycle after the head moves
    // Nothing retires while the flush is in progress
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_regmap_retire_en <= 1'b0;
            o_redirect         <= 1'b0;
        end else begin
            o_regmap_retire_en <= ~o_redirect & o_retire_en;
            o_redirect         <= ~o_redirect & o_retire_en & i_head_entry.redirect;
        end
    end

    // Record and target follow the head entry and are qualified by their strobes
    always_ff @(posedge clk) begin
        o_regmap_retire.tag   <= o_head_addr;
        o_regmap_retire.rdest <= i_head_entry.rdest;
        o_regmap_retire.data  <= i_head_entry.data;
        // Branches restart at their target, anything else replays from its pc
        if (i_head_entry.op == rob_types_pkg::ROB_OP_BR) begin
            o_redirect_addr <= i_head_entry.addr;
        end else begin
            o_redirect_addr <= i_head_entry.pc;
        end
    end

    // The allocator sees the flush and reports an empty buffer one cycle later
    assert property (@(posedge clk) disable iff (!n_rst)
        o_redirect |=> i_empty);

endmodule

//--- verilog/reorder_buffer.sv
//**********************************************************************
// Reorder buffer top: allocator, entry array and retire unit
//**********************************************************************

`timescale 1ns/1ps

`include "rob_params.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   i_regmap_rename_en,
    output rob_types_pkg::tag_t    o_regmap_rename_tag,
    output logic                   o_rob_stall,
    input  logic                   i_rob_enq_en,
    input  rob_types_pkg::enq_t    i_rob_enq,
    input  rob_bus_pkg::cdb_t      i_cdb [0:`ROB_CDB_DEPTH-1],
    output logic                   o_regmap_retire_en,
    output rob_bus_pkg::retire_t   o_regmap_retire,
    output logic                   o_redirect,
    output rob_types_pkg::addr_t   o_redirect_addr
);

    logic [`ROB_DEPTH-1:0] dispatch_en;
    logic                  empty;
    logic                  retire_en;
    rob_types_pkg::tag_t   head_addr;
    rob_types_pkg::ptr_t   head_next;
    rob_types_pkg::entry_t head_entry;

    // Stall is the full flag, the rename tag is the tail slot
    rob_alloc u_alloc (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_rename_en   (i_regmap_rename_en),
        .i_enq_en      (i_rob_enq_en),
        .i_retire_en   (retire_en),
        .i_redirect    (o_redirect),
        .i_head_next   (head_next),
        .o_tail_addr   (o_regmap_rename_tag),
        .o_dispatch_en (dispatch_en),
        .o_full        (o_rob_stall),
        .o_empty       (empty)
    );

    rob_entry_array u_entries (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_dispatch_en (dispatch_en),
        .i_enq         (i_rob_enq),
        .i_cdb         (i_cdb),
        .i_redirect    (o_redirect),
        .i_head_addr   (head_addr),
        .o_head_entry  (head_entry)
    );

    rob_retire u_retire (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_head_entry       (head_entry),
        .i_empty            (empty),
        .o_head_addr        (head_addr),
        .o_head_next        (head_next),
        .o_retire_en        (retire_en),
        .o_redirect         (o_redirect),
        .o_redirect_addr    (o_redirect_addr),
        .o_regmap_retire_en (o_regmap_retire_en),
        .o_regmap_retire    (o_regmap_retire)
    );

endmodule

//--- verification/tb_reorder_buffer.sv
//**********************************************************************
// Reorder buffer testbench: stimulus table, shuffled writebacks on both
// data-bus ports, retire scoreboard and typed compare tasks
//**********************************************************************

`timescale 1ns/1ps

`include "rob_params.svh"

module tb_reorder_buffer;

    // One instruction: enqueue payload, writeback result, flush flag, completion delay
    typedef struct packed {
        rob_types_pkg::rob_op_e op;
        rob_types_pkg::addr_t   pc;
        rob_types_pkg::reg_t    rdest;
        rob_types_pkg::data_t   data;
        rob_types_pkg::addr_t   addr;
        logic                   redir;
        logic [1:0]             delay;
    } row_t;

    // Predicted retirement and the restart address when a flush is due
    typedef struct packed {
        rob_bus_pkg::retire_t rec;
        logic                 redir;
        rob_types_pkg::addr_t target;
    } exp_t;

    localparam rob_types_pkg::rob_op_e OP_INT = rob_types_pkg::ROB_OP_INT;
    localparam rob_types_pkg::rob_op_e OP_BR  = rob_types_pkg::ROB_OP_BR;

    logic                 clk;
    logic                 n_rst;
    logic                 rename_en;
    logic                 enq_en;
    logic                 stall;
    logic                 retire_en;
    logic                 redirect;
    rob_types_pkg::enq_t  enq;
    rob_types_pkg::tag_t  rename_tag;
    rob_types_pkg::addr_t redirect_addr;
    rob_bus_pkg::cdb_t    cdb [0:`ROB_CDB_DEPTH-1];
    rob_bus_pkg::retire_t retire;

    row_t   tbl [0:15];
    int     batch_len [0:2] = '{8, 5, 3};
    exp_t   exp_q [$];
    exp_t   mon_exp;
    integer seed = 38;
    int     errors = 0;
    int     timeouts = 0;

    reorder_buffer dut (
        .clk (clk), .n_rst (n_rst),
        .i_regmap_rename_en (rename_en), .o_regmap_rename_tag (rename_tag),
        .o_rob_stall (stall), .i_rob_enq_en (enq_en), .i_rob_enq (enq), .i_cdb (cdb),
        .o_regmap_retire_en (retire_en), .o_regmap_retire (retire),
        .o_redirect (redirect), .o_redirect_addr (redirect_addr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_types_pkg::tag_t got,
                             input rob_types_pkg::tag_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_retire(input string name, input rob_bus_pkg::retire_t got,
                                input rob_bus_pkg::retire_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_redirect(input string name, input rob_types_pkg::addr_t got,
                                  input rob_types_pkg::addr_t exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Batch 1 fills the buffer and ends in a flagged INT op, batch 2 flushes on a branch
    task automatic load_table();
        tbl[0]  = '{OP_INT, 32'h0000_1000, 5'd1,  32'hA000_0001, 32'h0,         1'b0, 2'd1};
        tbl[1]  = '{OP_BR,  32'h0000_1004, 5'd2,  32'hA000_0002, 32'h0000_2000, 1'b0, 2'd0};
        tbl[2]  = '{OP_INT, 32'h0000_1008, 5'd3,  32'hA000_0003, 32'h0,         1'b0, 2'd2};
        tbl[3]  = '{OP_INT, 32'h0000_100C, 5'd4,  32'hA000_0004, 32'h0,         1'b0, 2'd0};
        tbl[4]  = '{OP_BR,  32'h0000_1010, 5'd0,  32'hA000_0005, 32'h0000_2400, 1'b0, 2'd1};
        tbl[5]  = '{OP_INT, 32'h0000_1014, 5'd6,  32'hA000_0006, 32'h0,         1'b0, 2'd3};
        tbl[6]  = '{OP_INT, 32'h0000_1018, 5'd7,  32'hA000_0007, 32'h0,         1'b0, 2'd0};
        tbl[7]  = '{OP_INT, 32'h0000_101C, 5'd8,  32'hA000_0008, 32'h0000_0BAD, 1'b1, 2'd1};
        tbl[8]  = '{OP_INT, 32'h0000_3000, 5'd9,  32'hB000_0001, 32'h0,         1'b0, 2'd1};
        tbl[9]  = '{OP_INT, 32'h0000_3004, 5'd10, 32'hB000_0002, 32'h0,         1'b0, 2'd0};
        tbl[10] = '{OP_BR,  32'h0000_3008, 5'd11, 32'hB000_0003, 32'h0000_4000, 1'b1, 2'd2};
        tbl[11] = '{OP_INT, 32'h0000_300C, 5'd12, 32'hB000_0004, 32'h0,         1'b0, 2'd0};
        tbl[12] = '{OP_INT, 32'h0000_3010, 5'd13, 32'hB000_0005, 32'h0,         1'b0, 2'd1};
        tbl[13] = '{OP_INT, 32'h0000_4000, 5'd14, 32'hC000_0001, 32'h0,         1'b0, 2'd1};
        tbl[14] = '{OP_BR,  32'h0000_4004, 5'd15, 32'hC000_0002, 32'h0000_5000, 1'b0, 2'd0};
        tbl[15] = '{OP_INT, 32'h0000_4008, 5'd16, 32'hC000_0003, 32'h0,         1'b0, 2'd2};
    endtask

    // Writebacks in shuffled order, a zero delay pairs a result onto the other port
    task automatic complete_batch(input int base, input int n);
        int order [0:`ROB_DEPTH-1];
        int i;
        int j;
        int t;
        int p;
        for (i = 0; i < n; i++) order[i] = i;
        for (i = n - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        i = 0;
        while (i < n) begin
            repeat (tbl[base+order[i]].delay) next_cycle();
            p = $unsigned($random(seed)) % 2;
            cdb[p] = '{1'b1, tbl[base+order[i]].redir, rob_types_pkg::tag_t'(order[i]),
                       tbl[base+order[i]].data, tbl[base+order[i]].addr};
            i++;
            if (i < n && tbl[base+order[i]].delay == 0) begin
                cdb[1-p] = '{1'b1, tbl[base+order[i]].redir, rob_types_pkg::tag_t'(order[i]),
                             tbl[base+order[i]].data, tbl[base+order[i]].addr};
                i++;
            end
            next_cycle();
            cdb[0] = '0;
            cdb[1] = '0;
        end
    endtask

    task automatic run_batch(input int base, input int n);
        int   i;
        int   cnt;
        exp_t e;
        for (i = 0; i < n; i++) begin
            rename_en = 1'b1;
            check_tag("o_regmap_rename_tag", rename_tag, rob_types_pkg::tag_t'(i));
            next_cycle();
            rename_en = 1'b0;
            enq_en = 1'b1;
            enq = '{tbl[base+i].op, tbl[base+i].pc, tbl[base+i].rdest};
            next_cycle();
            enq_en = 1'b0;
        end
        // A full buffer stalls and an extra rename leaves the wrapped tag alone
        if (n == `ROB_DEPTH) begin
            check_bit("o_rob_stall", stall, 1'b1);
            check_tag("o_regmap_rename_tag", rename_tag, rob_types_pkg::tag_t'(n));
            rename_en = 1'b1;
            next_cycle();
            rename_en = 1'b0;
            check_tag("o_regmap_rename_tag", rename_tag, rob_types_pkg::tag_t'(n));
            check_bit("o_rob_stall", stall, 1'b1);
        end
        // Retirements follow program order and stop at the first flagged entry
        for (i = 0; i < n; i++) begin
            e.rec   = '{rob_types_pkg::tag_t'(i), tbl[base+i].rdest, tbl[base+i].data};
            e.redir = tbl[base+i].redir;
            e.target = (tbl[base+i].op == OP_BR) ? tbl[base+i].addr : tbl[base+i].pc;
            exp_q.push_back(e);
            if (tbl[base+i].redir) break;
        end
        complete_batch(base, n);
        cnt = 0;
        while (exp_q.size() != 0 && cnt < 100) begin
            @(posedge clk);
            cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d predicted retirements never came out", exp_q.size());
            timeouts++;
        end
        // The flush lands on the edge after the redirect pulse
        next_cycle();
        next_cycle();
    endtask

    // Retire and redirect outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (n_rst && retire_en) begin
            if (exp_q.size() == 0) begin
                $display("A retirement of tag %h appeared that was never expected", retire.tag);
                errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                check_retire("o_regmap_retire", retire, mon_exp.rec);
                if (mon_exp.redir && !redirect) begin
                    $display("Flagged entry retired without a redirect pulse");
                    errors++;
                end else if (mon_exp.redir) begin
                    check_redirect("o_redirect_addr", redirect_addr, mon_exp.target);
                end else if (redirect) begin
                    $display("Redirect raised for an entry that was not flagged");
                    errors++;
                end
            end
        end else if (n_rst && redirect) begin
            $display("Redirect raised without a retirement in the same cycle");
            errors++;
        end
    end

    initial begin
        #100000;
        $display("Simulation did not finish within the time limit");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int base;
        n_rst = 1'b0;
        rename_en = 1'b0;
        enq_en = 1'b0;
        enq = '0;
        for (int p = 0; p < `ROB_CDB_DEPTH; p++) cdb[p] = '0;
        load_table();
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        check_bit("o_regmap_retire_en", retire_en, 1'b0);
        check_bit("o_redirect", redirect, 1'b0);
        check_bit("o_rob_stall", stall, 1'b0);
        check_tag("o_regmap_rename_tag", rename_tag, '0);
        base = 0;
        for (int b = 0; b < 3; b++) begin
            run_batch(base, batch_len[b]);
            base += batch_len[b];
        end
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/rob_types_pkg.sv
verilog/rob_bus_pkg.sv
verilog/rob_alloc.sv
verilog/rob_entry_array.sv
verilog/rob_retire.sv
verilog/reorder_buffer.sv
verification/tb_reorder_buffer.sv
